// File: sdram_pkg.sv
package sdram_pkg;

  // request word address holds row, bank and column from the msb down
  localparam int ROW_W     = 12;
  localparam int BANK_W    = 2;
  localparam int COL_W     = 12;
  localparam int WORD_W    = ROW_W + BANK_W + COL_W;
  localparam int SD_ADDR_W = 13;
  localparam int WAIT_W    = 5;

  localparam int BANK_LSB  = COL_W;          // bank field position
  localparam int ROW_LSB   = COL_W + BANK_W; // row field position

  // SDRAM command codes in {ras, cas, we} style
  typedef enum logic [2:0] {
    MRST = 3'b000, // mode register set
    ARSR = 3'b001, // auto refresh
    PRCH = 3'b010, // precharge
    ACTV = 3'b011, // activate row
    WRTE = 3'b100, // write
    READ = 3'b101, // read
    BTRM = 3'b110, // burst terminate
    NOOP = 3'b111  // no operation
  } cmd_t;

  typedef logic [WORD_W-1:0]       word_addr_t;
  typedef logic [ROW_W-1:0]        row_t;
  typedef logic [BANK_W-1:0]       bank_t;
  typedef logic [COL_W-1:0]        col_t;
  typedef logic [SD_ADDR_W-1:0]    sd_addr_t;
  typedef logic [ROW_W+BANK_W-1:0] page_t;  // {row, bank}
  typedef logic [WAIT_W-1:0]       wait_t;

  // A10 high selects all banks on precharge
  localparam sd_addr_t PRECHARGE_ALL_ADDR = 13'h0400;

endpackage

// File: port_arbiter.sv
module port_arbiter
  import sdram_pkg::*;
(
  input  logic       CLK,
  input  logic       RST,
  // random port
  input  logic       rand_valid,
  input  word_addr_t rand_addr,
  input  logic       rand_we,
  output logic       rand_ready,
  // bulk port
  input  logic       bulk_valid,
  input  word_addr_t bulk_addr,
  input  logic       bulk_we,
  output logic       bulk_ready,
  // request slot towards the sequencer
  input  logic       slot_take,
  output logic       slot_valid,
  output word_addr_t slot_addr,
  output logic       slot_we
);

  logic accept_en; // low through reset and the first cycle after

  // only one port is offered the empty slot, bulk wins ties
  assign bulk_ready = accept_en && !slot_valid && (bulk_valid || !rand_valid);
  assign rand_ready = accept_en && !slot_valid && rand_valid && !bulk_valid;

  always_ff @(posedge CLK)
  begin
    if (!RST)
    begin
      accept_en  <= 1'b0;
      slot_valid <= 1'b0;
    end
    else
    begin
      accept_en <= 1'b1;
      if (slot_take)
        slot_valid <= 1'b0;
      else if ((bulk_valid && bulk_ready) || (rand_valid && rand_ready))
        slot_valid <= 1'b1;
    end
  end

  // payload only written when a port wins the slot
  always_ff @(posedge CLK)
  begin
    if (bulk_valid && bulk_ready)
    begin
      slot_addr <= bulk_addr;
      slot_we   <= bulk_we;
    end
    else if (rand_valid && rand_ready)
    begin
      slot_addr <= rand_addr;
      slot_we   <= rand_we;
    end
  end

endmodule

// File: page_tracker.sv
module page_tracker
  import sdram_pkg::*;
(
  input  logic       CLK,
  input  logic       RST,
  input  word_addr_t slot_addr,
  input  cmd_t       next_cmd,
  input  logic       cmd_issue,
  output logic       page_open,
  output logic       page_hit,
  output sd_addr_t   addr_out,
  output bank_t      ba_out
);

  row_t  slot_row;
  bank_t slot_bank;
  col_t  slot_col;
  page_t open_page;
  bank_t open_bank;

  assign slot_row  = slot_addr[ROW_LSB +: ROW_W];
  assign slot_bank = slot_addr[BANK_LSB +: BANK_W];
  assign slot_col  = slot_addr[COL_W-1:0];
  assign open_bank = open_page[BANK_W-1:0];

  assign page_hit = page_open && ({slot_row, slot_bank} == open_page);

  always_comb
  begin
    case (next_cmd)
      ACTV:
      begin
        // row goes out around A10, which stays low
        addr_out = {slot_row[ROW_W-1 -: 2], 1'b0, slot_row[ROW_W-3:0]};
        ba_out   = slot_bank;
      end
      READ, WRTE:
      begin
        addr_out = {slot_col, 1'b0}; // 16-bit word column
        ba_out   = open_bank;
      end
      default:
      begin
        addr_out = PRECHARGE_ALL_ADDR;
        ba_out   = open_bank;
      end
    endcase
  end

  always_ff @(posedge CLK)
  begin
    if (!RST)
      page_open <= 1'b0;
    else if (cmd_issue && next_cmd == ACTV)
      page_open <= 1'b1;
    else if (cmd_issue && (next_cmd == PRCH || next_cmd == ARSR))
      page_open <= 1'b0; // precharge all closes every bank
  end

  always_ff @(posedge CLK)
  begin
    if (cmd_issue && next_cmd == ACTV)
      open_page <= {slot_row, slot_bank};
  end

endmodule

// File: timing_counter.sv
module timing_counter
  import sdram_pkg::*;
#(
  parameter int T_RCD            = 3,
  parameter int T_RP             = 3,
  parameter int T_RAS            = 5,
  parameter int T_WR             = 4,
  parameter int T_CCD            = 2,
  parameter int T_RFC            = 9,
  parameter int REFRESH_INTERVAL = 200
)
(
  input  logic CLK,
  input  logic RST,
  input  cmd_t next_cmd,
  input  logic cmd_issue,
  input  logic refresh_done,
  output logic may_issue,
  output logic ras_done,
  output logic refresh_due
);

  localparam int REF_W = $clog2(REFRESH_INTERVAL + 1);

  wait_t            wait_cnt;
  wait_t            ras_cnt;
  logic [REF_W-1:0] ref_cnt;

  // cycles to hold off after the issuing cycle itself
  function automatic wait_t spacing(input cmd_t c);
    wait_t w;
    case (c)
      ACTV:    w = wait_t'(T_RCD - 1);
      PRCH:    w = wait_t'(T_RP - 1);
      ARSR:    w = wait_t'(T_RFC - 1);
      READ:    w = wait_t'(T_CCD - 1);
      WRTE:    w = wait_t'(T_WR - 1);
      default: w = '0;
    endcase
    return w;
  endfunction

  assign may_issue = (wait_cnt == '0);
  assign ras_done  = (ras_cnt == '0);

  always_ff @(posedge CLK)
  begin
    if (!RST)
    begin
      wait_cnt    <= '0;
      ras_cnt     <= '0;
      ref_cnt     <= '0;
      refresh_due <= 1'b0;
    end
    else
    begin
      if (cmd_issue)
        wait_cnt <= spacing(next_cmd);
      else if (wait_cnt != '0)
        wait_cnt <= wait_cnt - 1'b1;

      if (cmd_issue && next_cmd == ACTV)
        ras_cnt <= wait_t'(T_RAS - 1); // row must stay open this long
      else if (ras_cnt != '0)
        ras_cnt <= ras_cnt - 1'b1;

      if (refresh_done)
      begin
        ref_cnt     <= '0;
        refresh_due <= 1'b0;
      end
      else if (!refresh_due)
      begin
        if (ref_cnt == REF_W'(REFRESH_INTERVAL - 1))
          refresh_due <= 1'b1; // held until the ARSR goes out
        else
          ref_cnt <= ref_cnt + 1'b1;
      end
    end
  end

endmodule

// File: command_sequencer.sv
module command_sequencer
  import sdram_pkg::*;
(
  input  logic     CLK,
  input  logic     RST,
  input  logic     slot_valid,
  input  logic     slot_we,
  input  logic     page_open,
  input  logic     page_hit,
  input  logic     may_issue,
  input  logic     ras_done,
  input  logic     refresh_due,
  output logic     slot_take,
  output logic     refresh_done,
  output cmd_t     next_cmd,
  output logic     cmd_issue,
  output cmd_t     cmd,
  input  sd_addr_t addr_in,
  input  bank_t    ba_in,
  output sd_addr_t addr,
  output bank_t    ba
);

  typedef enum logic [2:0] {
    IDLE,
    CLOSE,   // precharge pending
    OPEN,    // activate pending
    ACCESS,  // column command pending
    REFRESH  // auto refresh pending
  } state_t;

  state_t state, state_nxt;

  // command belonging to the current state
  always_comb
  begin
    case (state)
      CLOSE:   next_cmd = PRCH;
      OPEN:    next_cmd = ACTV;
      ACCESS:  next_cmd = slot_we ? WRTE : READ;
      REFRESH: next_cmd = ARSR;
      default: next_cmd = NOOP;
    endcase
  end

  always_comb
  begin
    state_nxt = state;
    cmd_issue = 1'b0;
    case (state)
      IDLE:
      begin
        if (refresh_due)
          state_nxt = page_open ? CLOSE : REFRESH; // refresh before any request
        else if (slot_valid)
        begin
          if (page_hit)
            state_nxt = ACCESS;
          else
            state_nxt = page_open ? CLOSE : OPEN;
        end
      end
      CLOSE:
      begin
        if (may_issue && ras_done)
        begin
          cmd_issue = 1'b1;
          state_nxt = refresh_due ? REFRESH : OPEN;
        end
      end
      OPEN:
      begin
        if (refresh_due)
          state_nxt = REFRESH; // bank is closed, refresh can go first
        else if (may_issue)
        begin
          cmd_issue = 1'b1;
          state_nxt = ACCESS;
        end
      end
      ACCESS:
      begin
        if (may_issue && page_hit)
        begin
          cmd_issue = 1'b1;
          state_nxt = IDLE;
        end
      end
      REFRESH:
      begin
        if (may_issue)
        begin
          cmd_issue = 1'b1;
          state_nxt = IDLE;
        end
      end
      default: state_nxt = IDLE;
    endcase
  end

  assign slot_take    = cmd_issue && (state == ACCESS);  // request served
  assign refresh_done = cmd_issue && (state == REFRESH);

  always_ff @(posedge CLK)
  begin
    if (!RST)
    begin
      state <= IDLE;
      cmd   <= NOOP;
      addr  <= PRECHARGE_ALL_ADDR;
      ba    <= '0;
    end
    else
    begin
      state <= state_nxt;
      if (cmd_issue)
      begin
        cmd  <= next_cmd;
        addr <= addr_in;
        ba   <= ba_in;
      end
      else
      begin
        cmd  <= NOOP;
        addr <= PRECHARGE_ALL_ADDR; // bank left as is on idle cycles
      end
    end
  end

endmodule

// File: sdram_cmd_top.sv
module sdram_cmd_top
  import sdram_pkg::*;
#(
  parameter int T_RCD            = 3,
  parameter int T_RP             = 3,
  parameter int T_RAS            = 5,
  parameter int T_WR             = 4,
  parameter int T_CCD            = 2,
  parameter int T_RFC            = 9,
  parameter int REFRESH_INTERVAL = 200
)
(
  input  logic       CLK,
  input  logic       RST,
  input  logic       rand_valid,
  input  word_addr_t rand_addr,
  input  logic       rand_we,
  output logic       rand_ready,
  input  logic       bulk_valid,
  input  word_addr_t bulk_addr,
  input  logic       bulk_we,
  output logic       bulk_ready,
  output cmd_t       cmd,
  output sd_addr_t   addr,
  output bank_t      ba
);

  logic       slot_valid, slot_we, slot_take;
  word_addr_t slot_addr;
  logic       page_open, page_hit;
  logic       may_issue, ras_done, refresh_due, refresh_done;
  cmd_t       next_cmd;
  logic       cmd_issue;
  sd_addr_t   addr_sel;
  bank_t      ba_sel;

  port_arbiter u_arbiter (
    .CLK, .RST,
    .rand_valid, .rand_addr, .rand_we, .rand_ready,
    .bulk_valid, .bulk_addr, .bulk_we, .bulk_ready,
    .slot_take, .slot_valid, .slot_addr, .slot_we
  );

  page_tracker u_page (
    .CLK, .RST, .slot_addr, .next_cmd, .cmd_issue,
    .page_open, .page_hit, .addr_out(addr_sel), .ba_out(ba_sel)
  );

  timing_counter #(
    .T_RCD(T_RCD), .T_RP(T_RP), .T_RAS(T_RAS), .T_WR(T_WR),
    .T_CCD(T_CCD), .T_RFC(T_RFC), .REFRESH_INTERVAL(REFRESH_INTERVAL)
  ) u_timing (
    .CLK, .RST, .next_cmd, .cmd_issue, .refresh_done,
    .may_issue, .ras_done, .refresh_due
  );

  command_sequencer u_seq (
    .CLK, .RST, .slot_valid, .slot_we, .page_open, .page_hit,
    .may_issue, .ras_done, .refresh_due, .slot_take, .refresh_done,
    .next_cmd, .cmd_issue, .cmd,
    .addr_in(addr_sel), .ba_in(ba_sel), .addr, .ba
  );

endmodule

// File: sdram_cmd_properties.sv
module sdram_cmd_properties
  import sdram_pkg::*;
#(
  parameter int T_RCD            = 3,
  parameter int T_RP             = 3,
  parameter int T_RAS            = 5,
  parameter int T_WR             = 4,
  parameter int T_CCD            = 2,
  parameter int T_RFC            = 9
)
(
  input logic CLK,
  input logic RST,
  input cmd_t cmd,
  input logic rand_ready,
  input logic bulk_ready
);
  timeunit 1ns;
  timeprecision 100ps;

  cmd_t last_cmd;
  logic have_last;
  int   gap;     // cycles since the last command
  int   act_gap; // cycles since the last ACTV

  function automatic int min_gap(input cmd_t c);
    case (c)
      ACTV:    return T_RCD;
      PRCH:    return T_RP;
      ARSR:    return T_RFC;
      READ:    return T_CCD;
      WRTE:    return T_WR;
      default: return 1;
    endcase
  endfunction

  always_ff @(posedge CLK)
  begin
    if (!RST)
    begin
      have_last <= 1'b0;
      last_cmd  <= NOOP;
      gap       <= 0;
      act_gap   <= 1000;
    end
    else
    begin
      if (cmd != NOOP)
      begin
        have_last <= 1'b1;
        last_cmd  <= cmd;
        gap       <= 1;
      end
      else if (gap < 1000)
        gap <= gap + 1;
      if (cmd == ACTV)
        act_gap <= 1;
      else if (act_gap < 1000)
        act_gap <= act_gap + 1;
    end
  end

  a_spacing: assert property (@(posedge CLK) disable iff (!RST)
    (cmd != NOOP && have_last) |-> gap >= min_gap(last_cmd))
    else $error("command spacing violated");

  a_ras: assert property (@(posedge CLK) disable iff (!RST)
    (cmd == PRCH) |-> act_gap >= T_RAS)
    else $error("precharge before tRAS elapsed");

  a_reset_noop: assert property (@(posedge CLK) !RST |=> cmd == NOOP)
    else $error("command issued during reset");

  a_one_ready: assert property (@(posedge CLK) disable iff (!RST)
    !(rand_ready && bulk_ready))
    else $error("both ports ready at once");

endmodule

bind sdram_cmd_top sdram_cmd_properties #(
  .T_RCD(T_RCD), .T_RP(T_RP), .T_RAS(T_RAS), .T_WR(T_WR),
  .T_CCD(T_CCD), .T_RFC(T_RFC)
) u_props (
  .CLK, .RST, .cmd, .rand_ready, .bulk_ready
);

// File: tb_sdram_cmd.sv
module tb_sdram_cmd
  import sdram_pkg::*;
();
  timeunit 1ns;
  timeprecision 100ps;

  localparam int T_RCD            = 3;
  localparam int T_RP             = 3;
  localparam int T_RAS            = 5;
  localparam int T_WR             = 4;
  localparam int T_CCD            = 2;
  localparam int T_RFC            = 9;
  localparam int REFRESH_INTERVAL = 200;
  localparam int NUM_RANDOM       = 300;
  localparam int NUM_DIRECTED     = 6;
  // worst request waits out tRAS, precharge, activate, column and write recovery
  localparam int SEQ_MAX      = T_RAS + T_RP + T_RCD + T_WR + 4;
  localparam int TRAFFIC_MAX  = (NUM_RANDOM + NUM_DIRECTED) * SEQ_MAX;
  localparam int REFRESH_LATE = REFRESH_INTERVAL + T_RAS + T_WR + T_RP + 4;
  localparam int TIMEOUT_CYCLES = 20 + TRAFFIC_MAX + 2 * REFRESH_LATE
                                + (TRAFFIC_MAX / REFRESH_INTERVAL + 4) * (T_RFC + T_RP + T_RAS);

  logic       CLK;
  logic       RST;
  logic       rand_valid, rand_we, rand_ready;
  logic       bulk_valid, bulk_we, bulk_ready;
  word_addr_t rand_addr, bulk_addr;
  cmd_t       cmd;
  sd_addr_t   addr;
  bank_t      ba;

  // reference model state
  word_addr_t req_addr[$];
  bit         req_we[$];
  bit         req_bulk[$];
  bit         served_bulk[$];
  cmd_t       exp_cmd[$];
  sd_addr_t   exp_addr[$];
  bank_t      exp_ba[$];
  bit         model_open;
  page_t      model_page;
  bit         arsr_pending; // refresh precharge seen and ARSR still to come
  int errors, served, accepted, act_count, prch_count, arsr_count, since_ref, cycles;

  sdram_cmd_top #(
    .T_RCD(T_RCD), .T_RP(T_RP), .T_RAS(T_RAS), .T_WR(T_WR),
    .T_CCD(T_CCD), .T_RFC(T_RFC), .REFRESH_INTERVAL(REFRESH_INTERVAL)
  ) UUT (
    .CLK, .RST,
    .rand_valid, .rand_addr, .rand_we, .rand_ready,
    .bulk_valid, .bulk_addr, .bulk_we, .bulk_ready,
    .cmd, .addr, .ba
  );

  always #50 CLK = ~CLK;

  // command list for one request from the page open when it starts
  function automatic int expected_cmds(input bit open, input page_t page, input word_addr_t a,
                                       input bit we, output cmd_t c[3], output sd_addr_t ad[3],
                                       output bank_t b[3]);
    row_t  r;
    bank_t bk;
    col_t  cl;
    int    n;
    r  = a[25:14];
    bk = a[13:12];
    cl = a[11:0];
    n  = 0;
    if (open && page != {r, bk})
    begin
      c[n] = PRCH;
      ad[n] = 13'h0400;
      b[n] = page[1:0];
      n++;
    end
    if (!open || page != {r, bk})
    begin
      c[n] = ACTV;
      ad[n] = {r[11:10], 1'b0, r[9:0]}; // A10 stays low
      b[n] = bk;
      n++;
    end
    c[n] = we ? WRTE : READ;
    ad[n] = {cl, 1'b0};
    b[n] = bk;
    n++;
    return n;
  endfunction

  task automatic load_expected();
    cmd_t     c[3];
    sd_addr_t ad[3];
    bank_t    b[3];
    int       n;
    exp_cmd.delete();
    exp_addr.delete();
    exp_ba.delete();
    if (req_addr.size() != 0)
    begin
      n = expected_cmds(model_open, model_page, req_addr[0], req_we[0], c, ad, b);
      for (int i = 0; i < n; i++)
      begin
        exp_cmd.push_back(c[i]);
        exp_addr.push_back(ad[i]);
        exp_ba.push_back(b[i]);
      end
    end
  endtask

  task automatic compare_value(input string name, input int got, input int exp);
    assert (got == exp)
    else
    begin
      errors++;
      $display("** Error at %0t: %s expected %0h got %0h", $time, name, exp, got);
    end
  endtask

  task automatic check_true(input bit cond, input string msg);
    assert (cond)
    else
    begin
      errors++;
      $display("** Error at %0t: %s", $time, msg);
    end
  endtask

  task automatic finish_run();
    $display("errors: %0d  accepted: %0d  served: %0d  refreshes: %0d",
             errors, accepted, served, arsr_count);
    if (errors == 0)
      $display("STATUS: PASS");
    else
      $display("STATUS: FAIL");
    $finish;
  endtask

  // drives one request and returns a little after the accepting edge
  task automatic send_request(input bit bulk, input word_addr_t a, input bit we);
    if (bulk)
    begin
      bulk_addr  = a;
      bulk_we    = we;
      bulk_valid = 1'b1;
    end
    else
    begin
      rand_addr  = a;
      rand_we    = we;
      rand_valid = 1'b1;
    end
    forever
    begin
      @(posedge CLK);
      if (bulk ? bulk_ready : rand_ready)
        break;
    end
    #1;
    if (bulk)
      bulk_valid = 1'b0;
    else
      rand_valid = 1'b0;
  endtask

  task automatic random_traffic(input bit bulk, input int count);
    int gap;
    for (int i = 0; i < count; i++)
    begin
      gap = int'($urandom_range(3));
      repeat (gap)
      begin
        @(posedge CLK);
        #1;
      end
      // few rows and two banks so that hits and misses both show up
      send_request(bulk, {row_t'($urandom_range(3)), bank_t'($urandom_range(1)),
                          col_t'($urandom)}, bit'($urandom_range(1)));
    end
  endtask

  task automatic wait_served(input int n);
    while (served < n)
      @(posedge CLK);
    #1;
  endtask

  // request intake sampled on the accepting edge
  always @(posedge CLK)
  begin
    if (RST && bulk_valid && bulk_ready)
    begin
      req_addr.push_back(bulk_addr);
      req_we.push_back(bulk_we);
      req_bulk.push_back(1'b1);
      accepted++;
    end
    else if (RST && rand_valid && rand_ready)
    begin
      req_addr.push_back(rand_addr);
      req_we.push_back(rand_we);
      req_bulk.push_back(1'b0);
      accepted++;
    end
  end

  // compare process on the command bus
  always @(posedge CLK)
  begin
    if (!RST)
      since_ref = 0;
    else
    begin
      since_ref++;
      check_true(since_ref <= REFRESH_LATE, "refresh overdue, no ARSR in time");
      if (cmd == NOOP)
        compare_value("addr", int'(addr), 32'h0400);
      else if (cmd == ARSR)
      begin
        check_true(!model_open, "ARSR issued while a page was open");
        check_true(since_ref >= REFRESH_INTERVAL, "ARSR came before the refresh interval");
        arsr_pending = 1'b0;
        arsr_count++;
        since_ref = 0;
        load_expected(); // pending request now starts from a closed page
      end
      else
      begin
        check_true(!arsr_pending, "refresh precharge not followed by ARSR");
        if (exp_cmd.size() == 0)
          load_expected();
        if (cmd == PRCH && (exp_cmd.size() == 0 || exp_cmd[0] != PRCH))
        begin
          check_true(model_open, "PRCH issued with no page open");
          compare_value("addr", int'(addr), 32'h0400);
          model_open   = 1'b0;
          arsr_pending = 1'b1;
          prch_count++;
        end
        else if (exp_cmd.size() == 0)
          check_true(1'b0, "command issued with no request pending");
        else
        begin
          compare_value("cmd", int'(cmd), int'(exp_cmd[0]));
          compare_value("addr", int'(addr), int'(exp_addr[0]));
          compare_value("ba", int'(ba), int'(exp_ba[0]));
          if (exp_cmd[0] == PRCH)
          begin
            model_open = 1'b0;
            prch_count++;
          end
          else if (exp_cmd[0] == ACTV)
          begin
            model_open = 1'b1;
            model_page = req_addr[0][25:12];
            act_count++;
          end
          else
          begin
            served_bulk.push_back(req_bulk[0]);
            void'(req_addr.pop_front());
            void'(req_we.pop_front());
            void'(req_bulk.pop_front());
            served++;
          end
          void'(exp_cmd.pop_front());
          void'(exp_addr.pop_front());
          void'(exp_ba.pop_front());
        end
      end
    end
  end

  always @(posedge CLK)
  begin
    cycles++;
    if (cycles > TIMEOUT_CYCLES)
    begin
      errors++;
      $display("timeout: run not finished after %0d cycles", TIMEOUT_CYCLES);
      finish_run();
    end
  end

  initial
  begin
    int acts, prchs, refs;
    CLK = 1'b0;
    RST = 1'b0;
    rand_valid = 1'b0;
    rand_addr  = '0;
    rand_we    = 1'b0;
    bulk_valid = 1'b0;
    bulk_addr  = '0;
    bulk_we    = 1'b0;
    void'($urandom(32'h2121));

    // reset state
    for (int i = 0; i < 8; i++)
    begin
      @(posedge CLK);
      #1;
      compare_value("cmd", int'(cmd), int'(NOOP));
      compare_value("addr", int'(addr), 32'h0400);
      compare_value("rand_ready", int'(rand_ready), 0);
      compare_value("bulk_ready", int'(bulk_ready), 0);
    end
    RST = 1'b1;
    @(posedge CLK);
    #1;
    compare_value("cmd", int'(cmd), int'(NOOP));
    compare_value("addr", int'(addr), 32'h0400);

    // page hit with one activate for two column commands
    send_request(1'b1, {12'd5, 2'd1, 12'h010}, 1'b1);
    send_request(1'b1, {12'd5, 2'd1, 12'h022}, 1'b0);
    wait_served(2);
    compare_value("act_count", act_count, 1);

    // page miss in the same bank
    send_request(1'b0, {12'd9, 2'd1, 12'h033}, 1'b0);
    wait_served(3);
    compare_value("prch_count", prch_count, 1);
    compare_value("act_count", act_count, 2);

    // both ports valid in the same cycle and bulk goes first
    fork
      send_request(1'b1, {12'd9, 2'd1, 12'h044}, 1'b1);
      send_request(1'b0, {12'd2, 2'd3, 12'h055}, 1'b0);
    join
    wait_served(5);
    check_true(served_bulk[3] && !served_bulk[4], "bulk request not served before random");
    compare_value("accepted", accepted, 5);

    // refresh with a page open and the same page activated again after it
    refs  = arsr_count;
    prchs = prch_count;
    while (arsr_count == refs)
      @(posedge CLK);
    #1;
    check_true(prch_count == prchs + 1, "no precharge ahead of the refresh");
    acts = act_count;
    send_request(1'b1, {12'd2, 2'd3, 12'h066}, 1'b1);
    wait_served(NUM_DIRECTED);
    compare_value("act_count", act_count, acts + 1);

    // mixed traffic on both ports
    fork
      random_traffic(1'b1, NUM_RANDOM / 2);
      random_traffic(1'b0, NUM_RANDOM - NUM_RANDOM / 2);
    join
    wait_served(NUM_DIRECTED + NUM_RANDOM);
    compare_value("accepted", accepted, served);
    check_true(req_addr.size() == 0 && exp_cmd.size() == 0, "requests left unserved");
    repeat (4) @(posedge CLK);
    finish_run();
  end

endmodule

// File: sim.f
sdram_pkg.sv
port_arbiter.sv
page_tracker.sv
timing_counter.sv
command_sequencer.sv
sdram_cmd_top.sv
sdram_cmd_properties.sv
tb_sdram_cmd.sv

// File: Makefile
SRCS := $(shell grep -v '^+' sim.f)
BIN  := obj_dir/Vtb_sdram_cmd

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SRCS) sim.f
	verilator --binary --timing --assert -f sim.f --top-module tb_sdram_cmd -Mdir obj_dir

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -qx "STATUS: PASS"

clean:
	rm -rf obj_dir
